// File: sd_autotest.f
hw/autotest_pkg.sv
hw/test_vector_regs.sv
hw/result_regs.sv
hw/autotest_sequencer.sv
hw/sd_autotest.sv
test/sd_card_model.sv
test/tb_sd_autotest.sv

// File: test/tb_sd_autotest.sv
/*
  tb_sd_autotest
  directed testbench for the SD cipher self-test harness, runs a set of
  vectors at short and at long busy latency
*/
`timescale 1ns/1ps

module tb_sd_autotest;

  localparam int NBLK    = 8;
  localparam int NVEC    = 4;
  localparam int TIMEOUT = 100000;

  logic                   clk;
  logic                   rst;
  logic                   sd_busy;
  logic [7:0]             sd_rdata;
  logic [7:0]             sd_wdata;
  logic                   sd_rst;
  logic                   sd_rd_block;
  logic                   sd_rd_byte;
  logic                   sd_wr_block;
  logic                   sd_wr_byte;
  autotest_pkg::sd_addr_t sd_addr;
  logic                   uut_rst;
  logic                   uut_end;
  autotest_pkg::text_t    uut_result;
  autotest_pkg::text_t    uut_text;
  autotest_pkg::key_t     uut_key;
  logic                   uut_encdec;
  autotest_pkg::count_t   err_count;
  logic                   done;

  autotest_pkg::text_t    v_text [0:NBLK-1];
  autotest_pkg::key_t     v_key [0:NBLK-1];
  logic                   v_enc [0:NBLK-1];
  logic                   v_good [0:NBLK-1];
  autotest_pkg::text_t    v_res [0:NBLK-1];
  autotest_pkg::cycles_t  exp_cycles [0:NBLK-1];
  logic [7:0]             saved [0:NVEC*512-1];
  int                     errors;
  int                     exp_errs;
  int                     run_blk;
  autotest_pkg::count_t   first_errs;

  sd_autotest DUT (
    .clk           (clk),
    .rst           (rst),
    .sd_busy_i     (sd_busy),
    .sd_data_i     (sd_rdata),
    .sd_rst_o      (sd_rst),
    .sd_rd_block_o (sd_rd_block),
    .sd_rd_byte_o  (sd_rd_byte),
    .sd_wr_block_o (sd_wr_block),
    .sd_wr_byte_o  (sd_wr_byte),
    .sd_addr_o     (sd_addr),
    .sd_data_o     (sd_wdata),
    .uut_text_i    (uut_result),
    .uut_end_i     (uut_end),
    .uut_rst_o     (uut_rst),
    .uut_text_o    (uut_text),
    .uut_key_o     (uut_key),
    .uut_encdec_o  (uut_encdec),
    .error_count_o (err_count),
    .done_o        (done)
  );

  sd_card_model #(.NBLK(NBLK)) card (
    .clk           (clk),
    .rst           (rst),
    .sd_rst_i      (sd_rst),
    .sd_rd_block_i (sd_rd_block),
    .sd_rd_byte_i  (sd_rd_byte),
    .sd_wr_block_i (sd_wr_block),
    .sd_wr_byte_i  (sd_wr_byte),
    .sd_addr_i     (sd_addr),
    .sd_data_i     (sd_wdata),
    .sd_busy_o     (sd_busy),
    .sd_data_o     (sd_rdata),
    .uut_rst_i     (uut_rst),
    .uut_text_i    (uut_text),
    .uut_key_i     (uut_key),
    .uut_encdec_i  (uut_encdec),
    .uut_text_o    (uut_result),
    .uut_end_o     (uut_end)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reference cycle count over cycles with the UUT out of reset and not yet done
  always @(negedge clk) begin
    if (!rst && !uut_rst && !uut_end) begin
      run_blk = sd_addr - autotest_pkg::START_BLOCK;
      if (run_blk >= 0 && run_blk < NBLK) begin
        exp_cycles[run_blk] = exp_cycles[run_blk] + 1;
      end
    end
  end

  task automatic check_text(input string name, input autotest_pkg::text_t exp,
                            input autotest_pkg::text_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_key(input string name, input autotest_pkg::key_t exp,
                           input autotest_pkg::key_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input autotest_pkg::count_t exp,
                             input autotest_pkg::count_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_cycles(input string name, input autotest_pkg::cycles_t exp,
                              input autotest_pkg::cycles_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp,
                            input logic [7:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout: %s", what);
    $display("errors: %0d", errors);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic put_vector(input int b, input autotest_pkg::text_t pt,
                            input autotest_pkg::key_t key, input logic enc,
                            input logic good);
    logic [31:0] sig;
    autotest_pkg::text_t res;
    autotest_pkg::text_t exp_field;
    int base;
    int i;
    sig  = autotest_pkg::SIG_VALUE;
    base = b * autotest_pkg::SD_BLOCK_BYTES;
    res  = enc ? (pt ^ key[63:0]) : ~(pt ^ key[63:0]);
    // a failing vector carries a corrupted expected result
    exp_field = good ? res : (res ^ 64'h8000_0000_0000_0001);
    v_text[b] = pt;
    v_key[b]  = key;
    v_enc[b]  = enc;
    v_good[b] = good;
    v_res[b]  = res;
    for (i = 0; i < 4; i++) begin
      card.rd_mem[base + autotest_pkg::OFS_SIG + i] = sig[8*(3-i) +: 8];
    end
    for (i = 0; i < 8; i++) begin
      card.rd_mem[base + autotest_pkg::OFS_TEXT + i]   = pt[8*i +: 8];
      card.rd_mem[base + autotest_pkg::OFS_EXPECT + i] = exp_field[8*i +: 8];
    end
    for (i = 0; i < 10; i++) begin
      card.rd_mem[base + autotest_pkg::OFS_KEY + i] = key[8*i +: 8];
    end
    card.rd_mem[base + autotest_pkg::OFS_MODE] = {7'h55, enc};
  endtask

  task automatic load_vectors;
    int i;
    int fill;
    for (i = 0; i < NBLK*512; i++) begin
      fill = i ^ (i >> 8);
      card.rd_mem[i] = fill[7:0];
    end
    put_vector(0, 64'h0123_4567_89AB_CDEF, 80'h0F1E_2D3C_4B5A_6978_8796, 1'b1, 1'b1);
    put_vector(1, 64'hFEDC_BA98_7654_3210, 80'h1357_9BDF_0246_8ACE_F0F0, 1'b0, 1'b1);
    put_vector(2, 64'h0F0F_1234_A5A5_5A5A, 80'hFFFF_0000_FFFF_1111_2222, 1'b1, 1'b0);
    put_vector(3, 64'hDEAD_0000_BEEF_4321, 80'h8888_7777_6666_5555_4444, 1'b0, 1'b0);
    put_vector(4, 64'h1111_2222_3333_4444, 80'h0000_1234_5678_9ABC_DEF0, 1'b1, 1'b1);
    // last signature byte off by one stops the run here
    card.rd_mem[4*512 + 3] = 8'hDE;
  endtask

  task automatic apply_reset(input string tag);
    int n;
    @(posedge clk);
    #5;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_byte({tag, " requests in reset"}, 8'h00,
               {4'h0, sd_rd_block, sd_rd_byte, sd_wr_block, sd_wr_byte});
    check_byte({tag, " uut_rst in reset"}, 8'h01, {7'h0, uut_rst});
    check_byte({tag, " done in reset"}, 8'h00, {7'h0, done});
    check_count({tag, " error count in reset"}, 0, err_count);
    @(posedge clk);
    #5;
    rst = 1'b0;
    n = 0;
    while (card.rst_reqs == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (card.rst_reqs == 0) timeout_abort({tag, ": no SD reset request after reset"});
  endtask

  task automatic process_block(input string tag, input int b);
    string name;
    autotest_pkg::text_t got_text;
    autotest_pkg::cycles_t got_cyc;
    int base;
    int i;
    int n;
    name = $sformatf("%s blk%0d", tag, b);
    base = b * autotest_pkg::SD_BLOCK_BYTES;
    n = 0;
    while (uut_rst && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (uut_rst) timeout_abort({name, ": UUT never released from reset"});
    check_text({name, " uut text"}, v_text[b], uut_text);
    check_key({name, " uut key"}, v_key[b], uut_key);
    check_byte({name, " uut mode"}, {7'h0, v_enc[b]}, {7'h0, uut_encdec});
    n = 0;
    while (card.wr_bytes[b] < 512 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (card.wr_bytes[b] < 512) timeout_abort({name, ": result block never written"});
    if (!v_good[b]) begin
      exp_errs++;
    end
    for (i = 0; i < 8; i++) begin
      got_text[8*i +: 8] = card.wr_mem[base + i];
    end
    for (i = 0; i < 4; i++) begin
      got_cyc[8*i +: 8] = card.wr_mem[base + 8 + i];
    end
    check_text({name, " result"}, v_res[b], got_text);
    check_cycles({name, " cycles"}, exp_cycles[b], got_cyc);
    check_byte({name, " match"}, {7'h0, v_good[b]}, card.wr_mem[base + 12]);
    for (i = 13; i < 512; i++) begin
      check_byte($sformatf("%s fill %0d", name, i), autotest_pkg::FILL_BYTE,
                 card.wr_mem[base + i]);
    end
    check_count({name, " error count"}, exp_errs, err_count);
  endtask

  task automatic expect_halt(input string tag, input int b);
    logic stray;
    int n;
    n = 0;
    while (!done && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!done) timeout_abort({tag, ": done never rose after bad signature"});
    stray = 1'b0;
    for (n = 0; n < 200; n++) begin
      @(negedge clk);
      if (sd_rst || sd_rd_block || sd_rd_byte || sd_wr_block || sd_wr_byte || !uut_rst) begin
        stray = 1'b1;
      end
    end
    if (stray) begin
      errors++;
      $display("%s: SD request or UUT release seen after halt", tag);
    end
    check_count({tag, " bad block bytes written"}, 0, card.wr_bytes[b]);
    check_count({tag, " final error count"}, exp_errs, err_count);
  endtask

  task automatic run_vectors(input string tag, input int lat);
    int b;
    card.lat_max  = lat;
    card.rst_reqs = 0;
    exp_errs      = 0;
    for (b = 0; b < NBLK; b++) begin
      card.wr_bytes[b] = 0;
      exp_cycles[b]    = 0;
    end
    apply_reset(tag);
    for (b = 0; b < NVEC; b++) begin
      process_block(tag, b);
    end
    expect_halt(tag, NVEC);
  endtask

  // same vectors with a slow host must give the same written blocks
  task automatic rerun_slow_host;
    int i;
    run_vectors("long", 24);
    for (i = 0; i < NVEC*512; i++) begin
      check_byte($sformatf("back-pressure byte %0d", i), saved[i], card.wr_mem[i]);
    end
    check_count("back-pressure error count", first_errs, err_count);
  endtask

  initial begin
    int i;
    errors = 0;
    rst    = 1'b1;
    load_vectors();
    run_vectors("short", 6);
    for (i = 0; i < NVEC*512; i++) begin
      saved[i] = card.wr_mem[i];
    end
    first_errs = exp_errs;
    rerun_slow_host();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: test/sd_card_model.sv
/*
  sd_card_model
  behavioral SD host with a block image store and random busy latency,
  plus a stand-in for the cipher under test
*/
`timescale 1ns/1ps

module sd_card_model #(
  parameter int NBLK    = 8,
  parameter int UUT_LAT = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sd_rst_i,
  input  logic                   sd_rd_block_i,
  input  logic                   sd_rd_byte_i,
  input  logic                   sd_wr_block_i,
  input  logic                   sd_wr_byte_i,
  input  autotest_pkg::sd_addr_t sd_addr_i,
  input  logic [7:0]             sd_data_i,
  output logic                   sd_busy_o,
  output logic [7:0]             sd_data_o,
  input  logic                   uut_rst_i,
  input  autotest_pkg::text_t    uut_text_i,
  input  autotest_pkg::key_t     uut_key_i,
  input  logic                   uut_encdec_i,
  output autotest_pkg::text_t    uut_text_o,
  output logic                   uut_end_o
);

  logic [7:0] rd_mem [0:NBLK*512-1];
  logic [7:0] wr_mem [0:NBLK*512-1];
  int         wr_bytes [0:NBLK-1];
  int         rst_reqs = 0;
  int         lat_max = 6;
  integer     seed = 32'h901b;
  int         run_cnt;
  int         blk;
  int         ptr;
  logic       in_block;

  // busy for 1 to lat_max cycles, read data appears as busy falls
  task automatic busy_cycle(input logic [7:0] data);
    int n;
    n = 1 + ($unsigned($random(seed)) % lat_max);
    sd_busy_o = 1'b1;
    sd_data_o = 8'hxx;
    repeat (n) @(posedge clk);
    #1;
    sd_busy_o = 1'b0;
    sd_data_o = data;
  endtask

  initial begin
    sd_busy_o = 1'b0;
    sd_data_o = 8'h00;
    uut_end_o = 1'b0;
    in_block  = 1'b0;
    ptr       = 0;
    forever begin
      @(posedge clk);
      #1;
      blk = sd_addr_i - autotest_pkg::START_BLOCK;
      if (!sd_rd_block_i && !sd_wr_block_i) begin
        in_block = 1'b0;
        ptr      = 0;
      end
      if (rst) begin
        in_block = 1'b0;
      end else if (sd_rst_i) begin
        rst_reqs++;
        busy_cycle(8'h00);
      end else if (sd_rd_byte_i) begin
        busy_cycle((blk >= 0 && blk < NBLK) ? rd_mem[blk*512 + ptr] : 8'h00);
        ptr++;
      end else if (sd_wr_byte_i) begin
        if (blk >= 0 && blk < NBLK) begin
          wr_mem[blk*512 + ptr] = sd_data_i;
          wr_bytes[blk]++;
        end
        busy_cycle(8'h00);
        ptr++;
      end else if ((sd_rd_block_i || sd_wr_block_i) && !in_block) begin
        in_block = 1'b1;
        busy_cycle(8'h00);
      end
    end
  end

  // cipher stand-in, inverted result for decrypt
  assign uut_text_o = uut_encdec_i ? (uut_text_i ^ uut_key_i[63:0])
                                   : ~(uut_text_i ^ uut_key_i[63:0]);

  always @(posedge clk) begin
    #1;
    if (uut_rst_i) begin
      run_cnt   = 0;
      uut_end_o = 1'b0;
    end else begin
      run_cnt++;
      if (run_cnt >= UUT_LAT) begin
        uut_end_o = 1'b1;
      end
    end
  end

endmodule

// File: hw/sd_autotest.sv
/*
  sd_autotest
  SD-card-driven self-test harness for a 64-bit block cipher, sequencer
  beside the test vector and result register blocks
*/
`timescale 1ns/1ps

module sd_autotest (
  input  logic                   clk,
  input  logic                   rst,
  // SD host controller
  input  logic                   sd_busy_i,
  input  logic [7:0]             sd_data_i,
  output logic                   sd_rst_o,
  output logic                   sd_rd_block_o,
  output logic                   sd_rd_byte_o,
  output logic                   sd_wr_block_o,
  output logic                   sd_wr_byte_o,
  output autotest_pkg::sd_addr_t sd_addr_o,
  output logic [7:0]             sd_data_o,
  // cipher under test
  input  autotest_pkg::text_t    uut_text_i,
  input  logic                   uut_end_i,
  output logic                   uut_rst_o,
  output autotest_pkg::text_t    uut_text_o,
  output autotest_pkg::key_t     uut_key_o,
  output logic                   uut_encdec_o,
  // status
  output autotest_pkg::count_t   error_count_o,
  output logic                   done_o
);

  autotest_pkg::byte_idx_t byte_idx;
  autotest_pkg::text_t     expect_text;
  logic                    vec_clr;
  logic                    vec_wr;
  logic                    exec_clr;
  logic                    exec_en;
  logic                    capture;
  logic                    compare;
  logic                    sig_ok;

  autotest_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .sd_busy_i     (sd_busy_i),
    .uut_end_i     (uut_end_i),
    .sig_ok_i      (sig_ok),
    .sd_rst_o      (sd_rst_o),
    .sd_rd_block_o (sd_rd_block_o),
    .sd_rd_byte_o  (sd_rd_byte_o),
    .sd_wr_block_o (sd_wr_block_o),
    .sd_wr_byte_o  (sd_wr_byte_o),
    .sd_addr_o     (sd_addr_o),
    .uut_rst_o     (uut_rst_o),
    .byte_idx_o    (byte_idx),
    .vec_clr_o     (vec_clr),
    .vec_wr_o      (vec_wr),
    .exec_clr_o    (exec_clr),
    .exec_en_o     (exec_en),
    .capture_o     (capture),
    .compare_o     (compare),
    .done_o        (done_o)
  );

  test_vector_regs u_vec (
    .clk        (clk),
    .rst        (rst),
    .clr_i      (vec_clr),
    .wr_i       (vec_wr),
    .byte_idx_i (byte_idx),
    .data_i     (sd_data_i),
    .text_o     (uut_text_o),
    .key_o      (uut_key_o),
    .encdec_o   (uut_encdec_o),
    .expect_o   (expect_text),
    .sig_ok_o   (sig_ok)
  );

  result_regs u_res (
    .clk           (clk),
    .rst           (rst),
    .exec_clr_i    (exec_clr),
    .exec_en_i     (exec_en),
    .capture_i     (capture),
    .compare_i     (compare),
    .uut_text_i    (uut_text_i),
    .expect_i      (expect_text),
    .byte_idx_i    (byte_idx),
    .data_o        (sd_data_o),
    .error_count_o (error_count_o)
  );

endmodule

// File: hw/autotest_sequencer.sv
/*
  autotest_sequencer
  FSM for the self-test run: SD reset, block read, signature check, UUT run,
  result compare and block write-back, then on to the next address
*/
`timescale 1ns/1ps

module autotest_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sd_busy_i,
  input  logic                    uut_end_i,
  input  logic                    sig_ok_i,
  output logic                    sd_rst_o,
  output logic                    sd_rd_block_o,
  output logic                    sd_rd_byte_o,
  output logic                    sd_wr_block_o,
  output logic                    sd_wr_byte_o,
  output autotest_pkg::sd_addr_t  sd_addr_o,
  output logic                    uut_rst_o,
  output autotest_pkg::byte_idx_t byte_idx_o,
  output logic                    vec_clr_o,
  output logic                    vec_wr_o,
  output logic                    exec_clr_o,
  output logic                    exec_en_o,
  output logic                    capture_o,
  output logic                    compare_o,
  output logic                    done_o
);

  typedef enum logic [3:0] {
    S_SD_RST,
    S_IDLE,
    S_RD_REQ,
    S_RD_BYTE,
    S_SIG_CHECK,
    S_RUN,
    S_CAPTURE,
    S_COMPARE,
    S_WR_REQ,
    S_WR_BYTE,
    S_ADDR_ADV,
    S_HALT
  } state_t;

  state_t                  state;
  state_t                  state_nxt;
  logic                    busy_seen;
  logic                    in_hs;
  logic                    xfer_done;
  logic                    last_byte;
  autotest_pkg::byte_idx_t byte_cnt;
  autotest_pkg::sd_addr_t  blk_addr;

  // states that run the strobe and busy handshake
  assign in_hs = (state == S_SD_RST) || (state == S_RD_REQ) || (state == S_RD_BYTE) ||
                 (state == S_WR_REQ) || (state == S_WR_BYTE);

  // step finished once busy has risen and fallen again
  assign xfer_done = in_hs && busy_seen && !sd_busy_i;

  assign last_byte = (byte_cnt == autotest_pkg::byte_idx_t'(autotest_pkg::SD_BLOCK_BYTES - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      S_SD_RST: begin
        if (xfer_done) begin
          state_nxt = S_IDLE;
        end
      end
      S_IDLE: begin
        if (!sd_busy_i) begin
          state_nxt = S_RD_REQ;
        end
      end
      S_RD_REQ: begin
        if (xfer_done) begin
          state_nxt = S_RD_BYTE;
        end
      end
      S_RD_BYTE: begin
        if (xfer_done && last_byte) begin
          state_nxt = S_SIG_CHECK;
        end
      end
      S_SIG_CHECK: begin
        state_nxt = sig_ok_i ? S_RUN : S_HALT;
      end
      S_RUN: begin
        if (uut_end_i) begin
          state_nxt = S_CAPTURE;
        end
      end
      S_CAPTURE: state_nxt = S_COMPARE;
      S_COMPARE: state_nxt = S_WR_REQ;
      S_WR_REQ: begin
        if (xfer_done) begin
          state_nxt = S_WR_BYTE;
        end
      end
      S_WR_BYTE: begin
        if (xfer_done && last_byte) begin
          state_nxt = S_ADDR_ADV;
        end
      end
      S_ADDR_ADV: state_nxt = S_IDLE;
      S_HALT:     state_nxt = S_HALT;
      default:    state_nxt = S_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_SD_RST;
      busy_seen <= 1'b0;
    end else begin
      state <= state_nxt;
      if (xfer_done) begin
        busy_seen <= 1'b0;
      end else if (in_hs && sd_busy_i) begin
        busy_seen <= 1'b1;
      end
    end
  end

  // byte position within the current block
  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt <= '0;
    end else if ((state == S_IDLE) || (state == S_COMPARE)) begin
      byte_cnt <= '0;
    end else if (((state == S_RD_BYTE) || (state == S_WR_BYTE)) && xfer_done) begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      blk_addr <= autotest_pkg::START_BLOCK;
    end else if (state == S_ADDR_ADV) begin
      blk_addr <= blk_addr + 1'b1;
    end
  end

  // requests drop as soon as the host answers with busy
  assign sd_rst_o      = (state == S_SD_RST) && !busy_seen;
  assign sd_rd_block_o = (state == S_RD_REQ) || (state == S_RD_BYTE);
  assign sd_rd_byte_o  = (state == S_RD_BYTE) && !busy_seen;
  assign sd_wr_block_o = (state == S_WR_REQ) || (state == S_WR_BYTE);
  assign sd_wr_byte_o  = (state == S_WR_BYTE) && !busy_seen;
  assign sd_addr_o     = blk_addr;

  assign uut_rst_o  = (state != S_RUN);
  assign byte_idx_o = byte_cnt;
  assign vec_clr_o  = (state == S_IDLE);
  assign vec_wr_o   = (state == S_RD_BYTE) && xfer_done;
  assign exec_clr_o = (state == S_IDLE);
  assign exec_en_o  = (state == S_RUN) && !uut_end_i;
  assign capture_o  = (state == S_CAPTURE);
  assign compare_o  = (state == S_COMPARE);
  assign done_o     = (state == S_HALT);

endmodule

// File: hw/result_regs.sv
/*
  result_regs
  UUT output capture, execution cycle and mismatch counters, and byte
  selection for the result block written back to the card
*/
`timescale 1ns/1ps

module result_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    exec_clr_i,
  input  logic                    exec_en_i,
  input  logic                    capture_i,
  input  logic                    compare_i,
  input  autotest_pkg::text_t     uut_text_i,
  input  autotest_pkg::text_t     expect_i,
  input  autotest_pkg::byte_idx_t byte_idx_i,
  output logic [7:0]              data_o,
  output autotest_pkg::count_t    error_count_o
);

  autotest_pkg::text_t     out_text;
  autotest_pkg::cycles_t   cycles;
  logic                    match;
  autotest_pkg::count_t    err_cnt;

  autotest_pkg::byte_idx_t rel_text;
  autotest_pkg::byte_idx_t rel_cycles;

  // captured output
  always_ff @(posedge clk) begin
    if (capture_i) begin
      out_text <= uut_text_i;
    end
  end

  // cycles spent by the UUT on this vector
  always_ff @(posedge clk) begin
    if (rst || exec_clr_i) begin
      cycles <= '0;
    end else if (exec_en_i) begin
      cycles <= cycles + 1'b1;
    end
  end

  // mismatch counter runs across all blocks
  always_ff @(posedge clk) begin
    if (rst) begin
      match   <= 1'b0;
      err_cnt <= '0;
    end else if (compare_i) begin
      match <= (out_text == expect_i);
      if (out_text != expect_i) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

  assign rel_text   = byte_idx_i - autotest_pkg::OFS_RES_TEXT;
  assign rel_cycles = byte_idx_i - autotest_pkg::OFS_RES_CYCLES;

  // write block layout, lsb first for multi-byte fields
  always_comb begin
    data_o = autotest_pkg::FILL_BYTE;
    if (autotest_pkg::in_field(byte_idx_i, autotest_pkg::OFS_RES_TEXT,
                               autotest_pkg::TEXT_BYTES)) begin
      data_o = out_text[8*rel_text +: 8];
    end else if (autotest_pkg::in_field(byte_idx_i, autotest_pkg::OFS_RES_CYCLES,
                                        autotest_pkg::CYCLES_BYTES)) begin
      data_o = cycles[8*rel_cycles +: 8];
    end else if (byte_idx_i == autotest_pkg::OFS_RES_MATCH) begin
      data_o = {7'b0, match};
    end
  end

  assign error_count_o = err_cnt;

endmodule

// File: hw/test_vector_regs.sv
/*
  test_vector_regs
  captures signature, plaintext, key, mode and expected result from the
  SD read stream by byte index and checks the block signature
*/
`timescale 1ns/1ps

module test_vector_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clr_i,
  input  logic                    wr_i,
  input  autotest_pkg::byte_idx_t byte_idx_i,
  input  logic [7:0]              data_i,
  output autotest_pkg::text_t     text_o,
  output autotest_pkg::key_t      key_o,
  output logic                    encdec_o,
  output autotest_pkg::text_t     expect_o,
  output logic                    sig_ok_o
);

  logic [31:0]               sig;
  autotest_pkg::text_t       text;
  autotest_pkg::key_t        key;
  logic                      encdec;
  autotest_pkg::text_t       expect_val;

  autotest_pkg::byte_idx_t   rel_sig;
  autotest_pkg::byte_idx_t   rel_text;
  autotest_pkg::byte_idx_t   rel_key;
  autotest_pkg::byte_idx_t   rel_expect;

  assign rel_sig    = byte_idx_i - autotest_pkg::OFS_SIG;
  assign rel_text   = byte_idx_i - autotest_pkg::OFS_TEXT;
  assign rel_key    = byte_idx_i - autotest_pkg::OFS_KEY;
  assign rel_expect = byte_idx_i - autotest_pkg::OFS_EXPECT;

  always_ff @(posedge clk) begin
    if (rst || clr_i) begin
      sig        <= '0;
      text       <= '0;
      key        <= '0;
      encdec     <= 1'b0;
      expect_val <= '0;
    end else if (wr_i) begin
      // signature arrives msb first
      if (autotest_pkg::in_field(byte_idx_i, autotest_pkg::OFS_SIG,
                                 autotest_pkg::SIG_BYTES)) begin
        sig[8*(autotest_pkg::SIG_BYTES-1-rel_sig) +: 8] <= data_i;
      end
      if (autotest_pkg::in_field(byte_idx_i, autotest_pkg::OFS_TEXT,
                                 autotest_pkg::TEXT_BYTES)) begin
        text[8*rel_text +: 8] <= data_i;
      end
      if (autotest_pkg::in_field(byte_idx_i, autotest_pkg::OFS_KEY,
                                 autotest_pkg::KEY_BYTES)) begin
        key[8*rel_key +: 8] <= data_i;
      end
      if (byte_idx_i == autotest_pkg::OFS_MODE) begin
        encdec <= data_i[0];
      end
      if (autotest_pkg::in_field(byte_idx_i, autotest_pkg::OFS_EXPECT,
                                 autotest_pkg::TEXT_BYTES)) begin
        expect_val[8*rel_expect +: 8] <= data_i;
      end
    end
  end

  assign text_o   = text;
  assign key_o    = key;
  assign encdec_o = encdec;
  assign expect_o = expect_val;
  assign sig_ok_o = (sig == autotest_pkg::SIG_VALUE);

endmodule

// File: hw/autotest_pkg.sv
/*
  autotest_pkg
  types, SD block layout and constants shared by the cipher self-test harness
*/
package autotest_pkg;

  localparam int TEXT_W   = 64;
  localparam int KEY_W    = 80;
  localparam int CYCLES_W = 32;
  localparam int COUNT_W  = 32;
  localparam int ADDR_W   = 32;
  localparam int IDX_W    = 10;

  typedef logic [TEXT_W-1:0]   text_t;
  typedef logic [KEY_W-1:0]    key_t;
  typedef logic [CYCLES_W-1:0] cycles_t;
  typedef logic [COUNT_W-1:0]  count_t;
  typedef logic [ADDR_W-1:0]   sd_addr_t;
  typedef logic [IDX_W-1:0]    byte_idx_t;

  localparam int SD_BLOCK_BYTES = 512;

  // field lengths in bytes
  localparam int SIG_BYTES    = 4;
  localparam int TEXT_BYTES   = TEXT_W / 8;
  localparam int KEY_BYTES    = KEY_W / 8;
  localparam int CYCLES_BYTES = CYCLES_W / 8;

  localparam logic [31:0] SIG_VALUE = 32'hAABB_CCDD;

  // read block layout
  localparam byte_idx_t OFS_SIG    = 10'd0;
  localparam byte_idx_t OFS_TEXT   = 10'd4;
  localparam byte_idx_t OFS_KEY    = 10'd12;
  localparam byte_idx_t OFS_MODE   = 10'd22;
  localparam byte_idx_t OFS_EXPECT = 10'd23;

  // write block layout
  localparam byte_idx_t OFS_RES_TEXT   = 10'd0;
  localparam byte_idx_t OFS_RES_CYCLES = 10'd8;
  localparam byte_idx_t OFS_RES_MATCH  = 10'd12;

  localparam logic [7:0] FILL_BYTE = 8'hFF;

  localparam sd_addr_t START_BLOCK = 32'h0010_0000;

  // unsigned wrap makes indices below ofs fall outside too
  function automatic logic in_field(input byte_idx_t idx, input byte_idx_t ofs,
                                    input int unsigned len);
    byte_idx_t rel;
    rel = idx - ofs;
    return rel < len;
  endfunction

endpackage
